//--- project.f
rtl/ppu_pkg.sv
rtl/pal_fetch_if.sv
rtl/window_detector.sv
rtl/window_masker.sv
rtl/priority_eval.sv
rtl/pixel_sequencer.sv
rtl/palette_ram.sv
rtl/pixel_compositor.sv
sim/tb_clock.sv
sim/tb_pixel_compositor.sv

//--- rtl/pal_fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pal_fetch_if #(
    parameter int COL_W = 8
);
    logic [COL_W-1:0]      col;
    ppu_pkg::layer_word_t  bg_cur;    // background presented in the current sort step
    ppu_pkg::layer_word_t  obj;
    ppu_pkg::fetch_phase_e phase;
    logic                  first;
    logic                  send_address_1;
    logic                  send_address_2;
    logic                  read_data_1;
    logic                  read_data_2;

    modport ctrl (
        output col, bg_cur, obj, phase, first,
        output send_address_1, send_address_2, read_data_1, read_data_2
    );

    modport eval (
        input col, bg_cur, obj, phase, first,
        input send_address_1, send_address_2, read_data_1, read_data_2
    );

endinterface

`default_nettype wire

//--- rtl/palette_ram.sv
`timescale 1ns/1ps
`default_nettype none

module palette_ram #(
    parameter int PAL_DEPTH = 256
) (
    input  logic        clk,
    input  logic        we,
    input  logic [7:0]  waddr,
    input  logic [15:0] wdata,
    input  logic [7:0]  raddr,
    output logic [31:0] rdata
);

    localparam int PAIRS = PAL_DEPTH / 2;

    // even entries in the low bank, odd entries in the high bank
    logic [14:0] mem_lo [PAIRS];
    logic [14:0] mem_hi [PAIRS];

    always_ff @(posedge clk) begin
        if (we && !waddr[0]) begin
            mem_lo[waddr[7:1]] <= wdata[14:0];    // bit 15 of a color halfword is unused
        end
        if (we && waddr[0]) begin
            mem_hi[waddr[7:1]] <= wdata[14:0];
        end
    end

    // whole word pair comes back, the reader picks the halfword
    always_ff @(posedge clk) begin
        rdata <= {1'b0, mem_hi[raddr[7:1]], 1'b0, mem_lo[raddr[7:1]]};
    end

endmodule

`default_nettype wire

//--- rtl/pixel_compositor.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor #(
    parameter int COL_W     = 8,
    parameter int ROW_W     = 8,
    parameter int PAL_DEPTH = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pixel_start,
    input  ppu_pkg::layer_word_t bg0,
    input  ppu_pkg::layer_word_t bg1,
    input  ppu_pkg::layer_word_t bg2,
    input  ppu_pkg::layer_word_t bg3,
    input  ppu_pkg::layer_word_t obj,
    input  logic [COL_W-1:0]     col,
    input  logic [ROW_W-1:0]     row,
    input  logic [15:0]          win0h,
    input  logic [15:0]          win1h,
    input  logic [15:0]          win0v,
    input  logic [15:0]          win1v,
    input  logic [15:0]          winin,
    input  logic [15:0]          winout,
    input  logic [15:0]          dispcnt,
    input  logic                 pal_we,
    input  logic [7:0]           pal_waddr,
    input  logic [15:0]          pal_wdata,
    output logic                 busy,
    output logic                 pixel_done,
    output logic [14:0]          color0,
    output logic [14:0]          color1,
    output logic [4:0]           effects
);

    logic [7:0]  pal_raddr;
    logic [31:0] pal_rdata;

    pal_fetch_if #(.COL_W(COL_W)) fif ();

    pixel_sequencer #(.COL_W(COL_W)) u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_start (pixel_start),
        .bg0         (bg0),
        .bg1         (bg1),
        .bg2         (bg2),
        .bg3         (bg3),
        .obj         (obj),
        .col         (col),
        .busy        (busy),
        .pixel_done  (pixel_done),
        .fif         (fif.ctrl)
    );

    priority_eval #(.COL_W(COL_W), .ROW_W(ROW_W)) u_eval (
        .clk       (clk),
        .rst_n     (rst_n),
        .fif       (fif.eval),
        .row       (row),
        .win0h     (win0h),
        .win1h     (win1h),
        .win0v     (win0v),
        .win1v     (win1v),
        .winin     (winin),
        .winout    (winout),
        .dispcnt   (dispcnt),
        .pal_raddr (pal_raddr),
        .pal_rdata (pal_rdata),
        .color0    (color0),
        .color1    (color1),
        .effects   (effects)
    );

    palette_ram #(.PAL_DEPTH(PAL_DEPTH)) u_palette (
        .clk   (clk),
        .we    (pal_we),
        .waddr (pal_waddr),
        .wdata (pal_wdata),
        .raddr (pal_raddr),
        .rdata (pal_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/pixel_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_sequencer #(
    parameter int COL_W = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pixel_start,
    input  ppu_pkg::layer_word_t bg0,
    input  ppu_pkg::layer_word_t bg1,
    input  ppu_pkg::layer_word_t bg2,
    input  ppu_pkg::layer_word_t bg3,
    input  ppu_pkg::layer_word_t obj,
    input  logic [COL_W-1:0]     col,
    output logic                 busy,
    output logic                 pixel_done,
    pal_fetch_if.ctrl            fif
);

    localparam int STEP_W = $clog2(ppu_pkg::NUM_BG);

    ppu_pkg::fetch_phase_e phase_q;
    logic [STEP_W-1:0]     step_q;
    ppu_pkg::layer_word_t  bg_q [ppu_pkg::NUM_BG];
    ppu_pkg::layer_word_t  obj_q;
    logic [COL_W-1:0]      col_q;
    logic                  accept;

    assign accept = pixel_start && !busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            bg_q[0] <= bg0;
            bg_q[1] <= bg1;
            bg_q[2] <= bg2;
            bg_q[3] <= bg3;
            obj_q   <= obj;
            col_q   <= col;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_q <= ppu_pkg::IDLE;
            step_q  <= '0;
        end else begin
            case (phase_q)
                ppu_pkg::IDLE: begin
                    if (accept) begin
                        phase_q <= ppu_pkg::SORT;
                        step_q  <= '0;
                    end
                end
                ppu_pkg::SORT: begin
                    step_q <= step_q + STEP_W'(1);
                    if (step_q == STEP_W'(ppu_pkg::NUM_BG - 1)) begin
                        phase_q <= ppu_pkg::ADDR1;
                    end
                end
                ppu_pkg::ADDR1: phase_q <= ppu_pkg::READ1;
                ppu_pkg::READ1: phase_q <= ppu_pkg::READ2;
                ppu_pkg::READ2: phase_q <= ppu_pkg::DONE;
                default:        phase_q <= ppu_pkg::IDLE;
            endcase
        end
    end

    assign busy       = (phase_q != ppu_pkg::IDLE);
    assign pixel_done = (phase_q == ppu_pkg::DONE);

    assign fif.col            = col_q;
    assign fif.bg_cur         = bg_q[step_q];    // one background per sort step
    assign fif.obj            = obj_q;
    assign fif.phase          = phase_q;
    assign fif.first          = (phase_q == ppu_pkg::SORT) && (step_q == '0);
    assign fif.send_address_1 = (phase_q == ppu_pkg::ADDR1);
    assign fif.send_address_2 = (phase_q == ppu_pkg::READ1);
    assign fif.read_data_1    = (phase_q == ppu_pkg::READ1);
    assign fif.read_data_2    = (phase_q == ppu_pkg::READ2);

    a_done_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_done |=> (phase_q == ppu_pkg::IDLE))
        else $error("sequencer did not return to idle after pixel_done");

endmodule

`default_nettype wire

//--- rtl/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    // one candidate layer word as delivered by the tile and sprite stages
    typedef struct packed {
        logic       valid;     // opaque pixel present
        logic       is_obj;
        logic [1:0] bg_num;
        logic [1:0] prio;      // 0 is frontmost
        logic [1:0] obj_mode;
        logic [3:0] rsvd;
        logic [7:0] pal_index;
    } layer_word_t;

    typedef enum logic [2:0] {
        IDLE,
        SORT,
        ADDR1,
        READ1,
        READ2,
        DONE
    } fetch_phase_e;

    localparam int NUM_BG = 4;

    // bit of the 5-bit layer masks that enables the sprite layer
    localparam int MASK_OBJ_BIT = 4;

    localparam logic [7:0] BACKDROP_INDEX = 8'd0;

    // sprite mode that marks a sprite-window pixel
    localparam logic [1:0] OBJ_MODE_WIN = 2'd2;

endpackage

`default_nettype wire

//--- rtl/priority_eval.sv
`timescale 1ns/1ps
`default_nettype none

module priority_eval #(
    parameter int COL_W = 8,
    parameter int ROW_W = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    pal_fetch_if.eval        fif,
    input  logic [ROW_W-1:0] row,
    input  logic [15:0]      win0h,
    input  logic [15:0]      win1h,
    input  logic [15:0]      win0v,
    input  logic [15:0]      win1v,
    input  logic [15:0]      winin,
    input  logic [15:0]      winout,
    input  logic [15:0]      dispcnt,
    output logic [7:0]       pal_raddr,
    input  logic [31:0]      pal_rdata,
    output logic [14:0]      color0,
    output logic [14:0]      color1,
    output logic [4:0]       effects
);

    ppu_pkg::layer_word_t top_saved;
    ppu_pkg::layer_word_t bot_saved;
    ppu_pkg::layer_word_t top_next;
    ppu_pkg::layer_word_t bot_next;
    logic [ROW_W-1:0]     row_q;
    logic                 in_win0;
    logic                 in_win1;
    logic                 in_objwin;
    logic [4:0]           mask;
    logic [4:0]           win_effects;
    logic [7:0]           top_idx;
    logic [7:0]           bot_idx;
    logic [14:0]          top_color;
    logic [14:0]          top_half;
    logic [14:0]          bot_half;

    // lower prio first, then sprite over background, then the lower background number
    function automatic logic beats(input ppu_pkg::layer_word_t a,
                                   input ppu_pkg::layer_word_t b);
        logic better;
        if (a.prio != b.prio) begin
            better = (a.prio < b.prio);
        end else if (a.is_obj != b.is_obj) begin
            better = a.is_obj;
        end else begin
            better = (a.bg_num < b.bg_num);
        end
        return a.valid && (!b.valid || better);
    endfunction

    function automatic void insert_layer(input ppu_pkg::layer_word_t c,
                                         inout ppu_pkg::layer_word_t t,
                                         inout ppu_pkg::layer_word_t b);
        if (beats(c, t)) begin
            b = t;
            t = c;
        end else if (beats(c, b)) begin
            b = c;
        end
    endfunction

    window_detector #(.COL_W(COL_W), .ROW_W(ROW_W)) u_detector (
        .col       (fif.col),
        .row       (row_q),
        .win0h     (win0h),
        .win1h     (win1h),
        .win0v     (win0v),
        .win1v     (win1v),
        .obj_mode  (fif.obj.obj_mode),
        .dispcnt   (dispcnt),
        .in_win0   (in_win0),
        .in_win1   (in_win1),
        .in_objwin (in_objwin)
    );

    window_masker u_masker (
        .in_win0   (in_win0),
        .in_win1   (in_win1),
        .in_objwin (in_objwin),
        .winin     (winin),
        .winout    (winout),
        .dispcnt   (dispcnt),
        .mask      (mask),
        .effects   (win_effects)
    );

    always_comb begin
        ppu_pkg::layer_word_t bg_c;
        ppu_pkg::layer_word_t obj_c;
        bg_c        = fif.bg_cur;
        bg_c.valid  = fif.bg_cur.valid && mask[fif.bg_cur.bg_num];
        obj_c       = fif.obj;
        obj_c.valid = fif.obj.valid && mask[ppu_pkg::MASK_OBJ_BIT];
        top_next    = fif.first ? '0 : top_saved;
        bot_next    = fif.first ? '0 : bot_saved;
        // the sprite competes every step but may only hold one slot
        if ((top_next.valid && top_next.is_obj) || (bot_next.valid && bot_next.is_obj)) begin
            obj_c.valid = 1'b0;
        end
        insert_layer(bg_c, top_next, bot_next);
        insert_layer(obj_c, top_next, bot_next);
    end

    assign top_idx = top_saved.valid ? top_saved.pal_index : ppu_pkg::BACKDROP_INDEX;
    assign bot_idx = bot_saved.valid ? bot_saved.pal_index : ppu_pkg::BACKDROP_INDEX;

    always_comb begin
        if (fif.send_address_2) begin
            pal_raddr = bot_idx;
        end else if (fif.send_address_1) begin
            pal_raddr = top_idx;
        end else begin
            pal_raddr = ppu_pkg::BACKDROP_INDEX;
        end
    end

    assign top_half = top_idx[0] ? pal_rdata[30:16] : pal_rdata[14:0];
    assign bot_half = bot_idx[0] ? pal_rdata[30:16] : pal_rdata[14:0];

    always_ff @(posedge clk) begin
        if (fif.phase == ppu_pkg::SORT) begin
            top_saved <= top_next;
            bot_saved <= bot_next;
        end
        if (fif.phase == ppu_pkg::IDLE) begin
            row_q <= row;    // frozen once the sequencer leaves idle
        end
        if (fif.read_data_1) begin
            top_color <= top_half;
        end
    end

    // both colors change together so the pair stays coherent until the next pixel_done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            color0  <= '0;
            color1  <= '0;
            effects <= '0;
        end else if (fif.read_data_2) begin
            color0  <= top_color;
            color1  <= bot_half;
            effects <= win_effects;
        end
    end

    a_read_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(fif.read_data_1 && fif.read_data_2))
        else $error("both palette read strobes high");

    a_read_order: assert property (@(posedge clk) disable iff (!rst_n)
        fif.read_data_2 |-> $past(fif.read_data_1) && (fif.phase == ppu_pkg::READ2))
        else $error("second palette read without the first one before it");

endmodule

`default_nettype wire

//--- rtl/window_detector.sv
`timescale 1ns/1ps
`default_nettype none

module window_detector #(
    parameter int COL_W = 8,
    parameter int ROW_W = 8
) (
    input  logic [COL_W-1:0] col,
    input  logic [ROW_W-1:0] row,
    input  logic [15:0]      win0h,
    input  logic [15:0]      win1h,
    input  logic [15:0]      win0v,
    input  logic [15:0]      win1v,
    input  logic [1:0]       obj_mode,
    input  logic [15:0]      dispcnt,
    output logic             in_win0,
    output logic             in_win1,
    output logic             in_objwin
);

    logic h0_hit;
    logic v0_hit;
    logic h1_hit;
    logic v1_hit;

    // left or top bound sits in the high byte, the right or bottom bound is exclusive
    assign h0_hit = (col >= COL_W'(win0h[15:8])) && (col < COL_W'(win0h[7:0]));
    assign v0_hit = (row >= ROW_W'(win0v[15:8])) && (row < ROW_W'(win0v[7:0]));
    assign h1_hit = (col >= COL_W'(win1h[15:8])) && (col < COL_W'(win1h[7:0]));
    assign v1_hit = (row >= ROW_W'(win1v[15:8])) && (row < ROW_W'(win1v[7:0]));

    assign in_win0   = dispcnt[13] && h0_hit && v0_hit;
    assign in_win1   = dispcnt[14] && h1_hit && v1_hit;
    assign in_objwin = dispcnt[15] && (obj_mode == ppu_pkg::OBJ_MODE_WIN);

    always_comb begin
        a_win0_inverted: assert final (!(in_win0 &&
            ((win0h[15:8] > win0h[7:0]) || (win0v[15:8] > win0v[7:0]))))
            else $error("window 0 reports inside with inverted bounds");
        a_win1_inverted: assert final (!(in_win1 &&
            ((win1h[15:8] > win1h[7:0]) || (win1v[15:8] > win1v[7:0]))))
            else $error("window 1 reports inside with inverted bounds");
    end

endmodule

`default_nettype wire

//--- rtl/window_masker.sv
`timescale 1ns/1ps
`default_nettype none

module window_masker (
    input  logic        in_win0,
    input  logic        in_win1,
    input  logic        in_objwin,
    input  logic [15:0] winin,
    input  logic [15:0] winout,
    input  logic [15:0] dispcnt,
    output logic [4:0]  mask,
    output logic [4:0]  effects
);

    logic [5:0] ctrl_bits;
    logic       any_win;

    assign any_win = |dispcnt[15:13];

    // win0 wins over win1, which wins over the sprite window
    always_comb begin
        if (in_win0) begin
            ctrl_bits = winin[5:0];
        end else if (in_win1) begin
            ctrl_bits = winin[13:8];
        end else if (in_objwin) begin
            ctrl_bits = winout[13:8];
        end else begin
            ctrl_bits = winout[5:0];    // outside every window
        end
    end

    always_comb begin
        if (!any_win) begin
            mask    = 5'h1f;
            effects = 5'h1f;
        end else begin
            mask = ctrl_bits[4:0];
            // bit 5 turns the color effect on for the layers this window shows
            effects = ctrl_bits[5] ? ctrl_bits[4:0] : 5'b0;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lands 1 ns after an edge like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tb_pixel_compositor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pixel_compositor;

    localparam int N_RANDOM  = 24;
    localparam int N_TIES    = 10;
    localparam int N_MASKED  = 14;
    localparam int N_WINDOWS = 20;
    localparam int N_BUSY    = 4;
    localparam int N_PIXELS  = N_RANDOM + N_TIES + N_MASKED + N_WINDOWS + N_BUSY;
    // 8 cycles per pixel, two more of slack each, the palette fill and a margin
    localparam int LIMIT_CYCLES = 256 + N_PIXELS * 8 + N_PIXELS * 2 + 100;

    logic                 clk;
    logic                 rst_n;
    logic                 pixel_start;
    ppu_pkg::layer_word_t cand [5];    // bg0 to bg3, then the sprite
    logic [7:0]           col_in;
    logic [7:0]           row_in;
    logic [15:0]          win0h;
    logic [15:0]          win1h;
    logic [15:0]          win0v;
    logic [15:0]          win1v;
    logic [15:0]          winin;
    logic [15:0]          winout;
    logic [15:0]          dispcnt;
    logic                 pal_we;
    logic [7:0]           pal_waddr;
    logic [15:0]          pal_wdata;
    logic                 busy;
    logic                 pixel_done;
    logic [14:0]          color0;
    logic [14:0]          color1;
    logic [4:0]           effects;
    logic [14:0]          pal_copy [256];
    logic [14:0]          exp_color0;
    logic [14:0]          exp_color1;
    logic [4:0]           exp_effects;
    string                test_name;

    tb_clock #(.PERIOD(10), .RESET_CYCLES(4)) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pixel_compositor #(.COL_W(8), .ROW_W(8), .PAL_DEPTH(256)) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_start (pixel_start),
        .bg0         (cand[0]),
        .bg1         (cand[1]),
        .bg2         (cand[2]),
        .bg3         (cand[3]),
        .obj         (cand[4]),
        .col         (col_in),
        .row         (row_in),
        .win0h       (win0h),
        .win1h       (win1h),
        .win0v       (win0v),
        .win1v       (win1v),
        .winin       (winin),
        .winout      (winout),
        .dispcnt     (dispcnt),
        .pal_we      (pal_we),
        .pal_waddr   (pal_waddr),
        .pal_wdata   (pal_wdata),
        .busy        (busy),
        .pixel_done  (pixel_done),
        .color0      (color0),
        .color1      (color1),
        .effects     (effects)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [14:0] expv,
                                   input logic [14:0] actv);
        $display("Fail %s %s: expected %h actual %h", test_name, what, expv, actv);
        abort_run("output mismatch at pixel_done");
    endtask

    function automatic ppu_pkg::layer_word_t rand_layer(input int slot);
        ppu_pkg::layer_word_t w;
        w           = '0;
        w.valid     = ($urandom % 4) != 0;    // about one layer in four is transparent
        w.is_obj    = (slot == 4);
        w.bg_num    = (slot == 4) ? 2'd0 : 2'(slot);
        w.prio      = 2'($urandom);
        w.obj_mode  = (slot == 4) ? 2'($urandom) : 2'd0;
        w.pal_index = 8'($urandom);
        return w;
    endfunction

    task automatic randomize_layers();
        foreach (cand[i]) cand[i] = rand_layer(i);
    endtask

    task automatic set_prio_all(input logic [1:0] p);
        foreach (cand[i]) cand[i].prio = p;
    endtask

    // returns {effects, color0, color1} for the current candidates and registers
    function automatic logic [34:0] expected_pixel(input logic [7:0] c, input logic [7:0] r);
        logic       w0;
        logic       w1;
        logic       ow;
        logic [5:0] sel;
        logic [4:0] mask;
        logic [4:0] fx;
        logic [4:0] key;
        logic [4:0] best_key;
        logic [4:0] next_key;
        logic [7:0] idx0;
        logic [7:0] idx1;
        int         best;
        int         next;
        int         i;
        w0 = dispcnt[13] && (c >= win0h[15:8]) && (c < win0h[7:0])
             && (r >= win0v[15:8]) && (r < win0v[7:0]);
        w1 = dispcnt[14] && (c >= win1h[15:8]) && (c < win1h[7:0])
             && (r >= win1v[15:8]) && (r < win1v[7:0]);
        ow = dispcnt[15] && (cand[4].obj_mode == 2'd2);
        if (w0) begin
            sel = winin[5:0];
        end else if (w1) begin
            sel = winin[13:8];
        end else if (ow) begin
            sel = winout[13:8];
        end else begin
            sel = winout[5:0];
        end
        mask     = (dispcnt[15:13] == 3'b0) ? 5'h1f : sel[4:0];
        fx       = (dispcnt[15:13] == 3'b0) ? 5'h1f : (sel[5] ? sel[4:0] : 5'h0);
        best     = -1;
        next     = -1;
        best_key = '1;
        next_key = '1;
        for (i = 0; i < 5; i++) begin
            // smaller key wins and the sprite ranks ahead of any background of its prio
            key = (i == 4) ? {cand[i].prio, 3'b000} : {cand[i].prio, 1'b1, 2'(i)};
            if (cand[i].valid && mask[i]) begin
                if (best < 0 || key < best_key) begin
                    next     = best;
                    next_key = best_key;
                    best     = i;
                    best_key = key;
                end else if (next < 0 || key < next_key) begin
                    next     = i;
                    next_key = key;
                end
            end
        end
        idx0 = (best < 0) ? ppu_pkg::BACKDROP_INDEX : cand[best].pal_index;
        idx1 = (next < 0) ? ppu_pkg::BACKDROP_INDEX : cand[next].pal_index;
        return {fx, pal_copy[idx0], pal_copy[idx1]};
    endfunction

    task automatic fill_palette();
        int a;
        for (a = 0; a < 256; a++) begin
            pal_we      = 1'b1;
            pal_waddr   = 8'(a);
            pal_wdata   = 16'($urandom);
            pal_copy[a] = pal_wdata[14:0];
            @(posedge clk);
            #1;
        end
        pal_we = 1'b0;
    endtask

    task automatic run_pixel(input bit poke_busy);
        logic [34:0] expv;
        expv        = expected_pixel(col_in, row_in);
        exp_effects = expv[34:30];
        exp_color0  = expv[29:15];
        exp_color1  = expv[14:0];
        pixel_start = 1'b1;
        @(posedge clk);
        #1;
        pixel_start = 1'b0;
        if (poke_busy) begin
            @(posedge clk);
            #1;
            randomize_layers();    // a second request that must not disturb the first
            col_in      = 8'($urandom);
            row_in      = 8'($urandom);
            pixel_start = 1'b1;
            @(posedge clk);
            #1;
            pixel_start = 1'b0;
        end
        while (!pixel_done) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic window_point(input logic [7:0] c, input logic [7:0] r,
                                input logic [1:0] mode);
        randomize_layers();
        cand[4].obj_mode = mode;
        col_in           = c;
        row_in           = r;
        run_pixel(1'b0);
    endtask

    a_color0: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_done |-> color0 == exp_color0)
        else report_mismatch("color0", exp_color0, $sampled(color0));

    a_color1: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_done |-> color1 == exp_color1)
        else report_mismatch("color1", exp_color1, $sampled(color1));

    a_effects: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_done |-> effects == exp_effects)
        else report_mismatch("effects", 15'(exp_effects), 15'($sampled(effects)));

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (pixel_start && !busy) |=> !pixel_done [*7] ##1 pixel_done)
        else abort_run("pixel_done did not come 8 cycles after an accepted pixel_start");

    a_done_source: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_done |-> $past(pixel_start && !busy, 8))
        else abort_run("pixel_done without an accepted pixel_start 8 cycles before it");

    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> !busy && !pixel_done && color0 == '0 && color1 == '0)
        else abort_run("busy, pixel_done or the colors were not cleared by reset");

    initial begin
        #(LIMIT_CYCLES * 10);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(32'h88a6));
        pixel_start = 1'b0;
        foreach (cand[i]) cand[i] = '0;
        col_in      = '0;
        row_in      = '0;
        win0h       = '0;
        win1h       = '0;
        win0v       = '0;
        win1v       = '0;
        winin       = '0;
        winout      = '0;
        dispcnt     = '0;
        pal_we      = 1'b0;
        pal_waddr   = '0;
        pal_wdata   = '0;
        exp_color0  = '0;
        exp_color1  = '0;
        exp_effects = '0;
        test_name   = "reset";
        @(posedge rst_n);
        @(posedge clk);
        #1;
        fill_palette();

        test_name = "random_prio";
        repeat (N_RANDOM) begin
            randomize_layers();
            col_in = 8'($urandom);
            row_in = 8'($urandom);
            run_pixel(1'b0);
        end

        test_name = "tie_break";
        randomize_layers();
        foreach (cand[i]) cand[i].valid = 1'b1;
        set_prio_all(2'd1);
        run_pixel(1'b0);    // sprite over bg0
        cand[4].valid = 1'b0;
        set_prio_all(2'd2);
        run_pixel(1'b0);    // bg0 over bg1
        repeat (N_TIES - 2) begin
            randomize_layers();
            set_prio_all(2'($urandom));
            run_pixel(1'b0);
        end

        // win0 covers the screen so winin alone picks the mask
        test_name = "window_mask";
        dispcnt   = 16'h2000;
        win0h     = 16'h00ff;
        win0v     = 16'h00ff;
        repeat (N_MASKED - 2) begin
            randomize_layers();
            winin  = 16'($urandom);
            col_in = 8'($urandom % 255);
            row_in = 8'($urandom % 255);
            run_pixel(1'b0);
        end
        foreach (cand[i]) cand[i].valid = 1'b0;
        run_pixel(1'b0);
        randomize_layers();
        foreach (cand[i]) cand[i].valid = 1'b1;
        winin = 16'h0020;
        run_pixel(1'b0);

        test_name = "window_select";
        dispcnt   = 16'he000;
        win0h     = {8'd10, 8'd50};
        win0v     = {8'd10, 8'd50};
        win1h     = {8'd40, 8'd90};
        win1v     = {8'd40, 8'd90};
        winin     = 16'($urandom);
        winout    = 16'($urandom);
        window_point(8'd20, 8'd20, 2'd0);
        window_point(8'd45, 8'd45, 2'd2);      // win0 still rules inside the overlap
        window_point(8'd70, 8'd70, 2'd0);
        window_point(8'd120, 8'd120, 2'd2);
        window_point(8'd200, 8'd200, 2'd0);
        repeat (N_WINDOWS - 5) begin
            winin  = 16'($urandom);
            winout = 16'($urandom);
            window_point(8'($urandom % 128), 8'($urandom % 128), 2'($urandom));
        end

        test_name = "start_while_busy";
        dispcnt   = 16'h6000;
        repeat (N_BUSY) begin
            randomize_layers();
            winin  = 16'($urandom);
            col_in = 8'($urandom % 128);
            row_in = 8'($urandom % 128);
            run_pixel(1'b1);
        end

        repeat (3) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
